// File: Makefile
# Verilator build and run of the camera capture testbench

VERILATOR ?= verilator
TOP       ?= camera_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/cam_ctrl.sv
`timescale 1ns/1ps

module cam_ctrl (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,

    // APB slave
    input logic psel_i,
    input logic penable_i,
    input logic pwrite_i,
    input logic [cam_reg_pkg::ADDR_W-1:0] paddr_i,
    input logic [cam_reg_pkg::DATA_W-1:0] pwdata_i,
    output logic [cam_reg_pkg::DATA_W-1:0] prdata_o,
    output logic pready_o,
    output logic pslverr_o,

    // Capture buffer
    output logic capture_req_o,
    input logic busy_i,
    input logic done_i,
    input logic [cam_pix_pkg::CNT_W-1:0] frame_bytes_i,
    output logic [cam_pix_pkg::BUF_AW-1:0] rd_addr_o,
    input logic [7:0] rd_data_i,

    // Metering
    input logic [7:0] meter_red_i,
    input logic [7:0] meter_green_i,
    input logic [7:0] meter_blue_i
);
    import cam_pix_pkg::*;
    import cam_reg_pkg::*;

    logic access;
    logic data_rd;
    logic mapped;
    logic wait_q;
    logic capture_req_q;
    logic [CNT_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] avail;
    logic [DATA_W-1:0] rdata;

    assign access = psel_i && penable_i;
    assign data_rd = access && !pwrite_i && (paddr_i == REG_DATA);

    // DATA reads give the buffer one cycle to present the byte
    assign pready_o = access && (!data_rd || wait_q);
    assign pslverr_o = pready_o && !mapped;
    assign prdata_o = (pready_o && !pwrite_i) ? rdata : '0;

    assign avail = frame_bytes_i - rd_ptr_q;
    assign rd_addr_o = rd_ptr_q[BUF_AW-1:0];
    assign capture_req_o = capture_req_q;

    // Register read mux
    always_comb begin
        mapped = 1'b0;
        rdata = '0;
        case (paddr_i)
            REG_CTRL: begin
                mapped = 1'b1;
            end
            REG_STATUS: begin
                mapped = 1'b1;
                rdata[STAT_BUSY] = busy_i;
                rdata[STAT_DONE] = done_i;
            end
            REG_AVAIL: begin
                mapped = 1'b1;
                rdata[CNT_W-1:0] = avail;
            end
            REG_DATA: begin
                mapped = 1'b1;
                rdata[7:0] = rd_data_i;
            end
            REG_METER: begin
                mapped = 1'b1;
                rdata[METER_RED_LSB +: 8] = meter_red_i;
                rdata[METER_GREEN_LSB +: 8] = meter_green_i;
                rdata[METER_BLUE_LSB +: 8] = meter_blue_i;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            wait_q <= 1'b0;
            capture_req_q <= 1'b0;
            rd_ptr_q <= '0;
        end else begin
            wait_q <= data_rd && !wait_q;

            // One cycle pulse per completed CTRL write
            capture_req_q <= pready_o && pwrite_i && (paddr_i == REG_CTRL) &&
                             pwdata_i[CTRL_CAPTURE];

            // Rewind only when the buffer takes the request
            if (capture_req_q && !busy_i) begin
                rd_ptr_q <= '0;
            end else if (data_rd && wait_q) begin
                rd_ptr_q <= rd_ptr_q + CNT_W'(1);
            end
        end
    end

endmodule

// File: rtl/cam_pix_pkg.sv
package cam_pix_pkg;

    // Channel width of the debayered stream
    localparam int PIX_W = 10;

    // Sensor frame, shrunk for simulation
    localparam int SENSOR_W = 16;
    localparam int SENSOR_H = 12;

    // Crop window, start inclusive and end exclusive
    localparam int CROP_X0 = 4;
    localparam int CROP_X1 = 12;
    localparam int CROP_Y0 = 2;
    localparam int CROP_Y1 = 10;

    // One stored byte per cropped pixel
    localparam int BUF_DEPTH = (CROP_X1 - CROP_X0) * (CROP_Y1 - CROP_Y0);
    localparam int BUF_AW = $clog2(BUF_DEPTH);
    // Needs one extra bit to hold a full frame count
    localparam int CNT_W = BUF_AW + 1;
    localparam int METER_SHIFT = $clog2(BUF_DEPTH);

    // RGB332 byte, packed by field and read back raw
    typedef union packed {
        struct packed {
            logic [2:0] red;
            logic [2:0] green;
            logic [1:0] blue;
        } fields;
        logic [7:0] raw;
    } buf_byte_u;

endpackage

// File: rtl/cam_reg_pkg.sv
package cam_reg_pkg;

    // APB bus widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // Register map
    localparam logic [ADDR_W-1:0] REG_CTRL = 8'h00;
    localparam logic [ADDR_W-1:0] REG_STATUS = 8'h04;
    localparam logic [ADDR_W-1:0] REG_AVAIL = 8'h08;
    localparam logic [ADDR_W-1:0] REG_DATA = 8'h0C;
    localparam logic [ADDR_W-1:0] REG_METER = 8'h10;

    // CTRL bits
    localparam int CTRL_CAPTURE = 0;

    // STATUS bits
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;

    // METER byte lanes
    localparam int METER_RED_LSB = 0;
    localparam int METER_GREEN_LSB = 8;
    localparam int METER_BLUE_LSB = 16;

endpackage

// File: rtl/camera.sv
`timescale 1ns/1ps

module camera (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,

    // APB slave
    input logic psel_i,
    input logic penable_i,
    input logic pwrite_i,
    input logic [cam_reg_pkg::ADDR_W-1:0] paddr_i,
    input logic [cam_reg_pkg::DATA_W-1:0] pwdata_i,
    output logic [cam_reg_pkg::DATA_W-1:0] prdata_o,
    output logic pready_o,
    output logic pslverr_o,

    // Debayered pixel stream
    input logic pix_frame_valid_i,
    input logic pix_line_valid_i,
    input logic [cam_pix_pkg::PIX_W-1:0] pix_red_i,
    input logic [cam_pix_pkg::PIX_W-1:0] pix_green_i,
    input logic [cam_pix_pkg::PIX_W-1:0] pix_blue_i
);
    import cam_pix_pkg::*;

    logic capture_req;
    logic busy;
    logic done;
    logic [CNT_W-1:0] frame_bytes;
    logic [BUF_AW-1:0] rd_addr;
    logic [7:0] rd_data;
    logic [7:0] meter_red;
    logic [7:0] meter_green;
    logic [7:0] meter_blue;

    pixel_if sensor_if ();
    pixel_if crop_if ();

    assign sensor_if.frame_valid = pix_frame_valid_i;
    assign sensor_if.line_valid = pix_line_valid_i;
    assign sensor_if.red = pix_red_i;
    assign sensor_if.green = pix_green_i;
    assign sensor_if.blue = pix_blue_i;

    crop u_crop (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .in_if(sensor_if.sink),
        .out_if(crop_if.source)
    );

    // Metering sees the crop window only
    metering u_metering (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pix_if(crop_if.sink),
        .red_o(meter_red),
        .green_o(meter_green),
        .blue_o(meter_blue)
    );

    image_buffer u_image_buffer (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pix_if(crop_if.sink),
        .capture_req_i(capture_req),
        .busy_o(busy),
        .done_o(done),
        .frame_bytes_o(frame_bytes),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data)
    );

    cam_ctrl u_cam_ctrl (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .paddr_i(paddr_i),
        .pwdata_i(pwdata_i),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .capture_req_o(capture_req),
        .busy_i(busy),
        .done_i(done),
        .frame_bytes_i(frame_bytes),
        .rd_addr_o(rd_addr),
        .rd_data_i(rd_data),
        .meter_red_i(meter_red),
        .meter_green_i(meter_green),
        .meter_blue_i(meter_blue)
    );

endmodule

// File: rtl/crop.sv
`timescale 1ns/1ps

module crop (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,
    pixel_if.sink in_if,
    pixel_if.source out_if
);
    import cam_pix_pkg::*;

    // Position of the pixel currently on the input
    logic [$clog2(SENSOR_W+1)-1:0] col_q;
    logic [$clog2(SENSOR_H+1)-1:0] row_q;
    logic line_valid_q;
    logic in_window;

    assign in_window = (col_q >= CROP_X0) && (col_q < CROP_X1) &&
                       (row_q >= CROP_Y0) && (row_q < CROP_Y1);

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            col_q <= '0;
            row_q <= '0;
            line_valid_q <= 1'b0;
            out_if.frame_valid <= 1'b0;
            out_if.line_valid <= 1'b0;
        end else begin
            line_valid_q <= in_if.line_valid;

            // Column restarts in every line gap
            if (in_if.line_valid) begin
                col_q <= col_q + 1'b1;
            end else begin
                col_q <= '0;
            end

            // Next row begins once a line has ended
            if (!in_if.frame_valid) begin
                row_q <= '0;
            end else if (line_valid_q && !in_if.line_valid) begin
                row_q <= row_q + 1'b1;
            end

            out_if.frame_valid <= in_if.frame_valid;
            out_if.line_valid <= in_if.frame_valid && in_if.line_valid && in_window;
        end
    end

    // Pixel data follows the same one cycle delay
    always_ff @(posedge clock_spi_in) begin
        out_if.red <= in_if.red;
        out_if.green <= in_if.green;
        out_if.blue <= in_if.blue;
    end

endmodule

// File: rtl/image_buffer.sv
`timescale 1ns/1ps

module image_buffer (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,
    pixel_if.sink pix_if,
    input logic capture_req_i,
    output logic busy_o,
    output logic done_o,
    output logic [cam_pix_pkg::CNT_W-1:0] frame_bytes_o,
    input logic [cam_pix_pkg::BUF_AW-1:0] rd_addr_i,
    output logic [7:0] rd_data_o
);
    import cam_pix_pkg::*;

    logic armed_q;
    logic capturing_q;
    logic done_q;
    logic frame_valid_q;
    logic [CNT_W-1:0] wr_cnt_q;
    logic fv_rise;
    logic fv_fall;
    logic wr_en;
    buf_byte_u wr_byte;
    buf_byte_u mem [BUF_DEPTH];

    assign fv_rise = pix_if.frame_valid && !frame_valid_q;
    assign fv_fall = frame_valid_q && !pix_if.frame_valid;

    // The frame may open with a valid pixel, so write on the start cycle too
    assign wr_en = (capturing_q || (armed_q && fv_rise)) && pix_if.line_valid &&
                   (wr_cnt_q != CNT_W'(BUF_DEPTH));

    assign busy_o = armed_q || capturing_q;
    assign done_o = done_q;
    assign frame_bytes_o = wr_cnt_q;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            armed_q <= 1'b0;
            capturing_q <= 1'b0;
            done_q <= 1'b0;
            frame_valid_q <= 1'b0;
            wr_cnt_q <= '0;
        end else begin
            frame_valid_q <= pix_if.frame_valid;

            // Requests while busy are dropped
            if (capture_req_i && !busy_o) begin
                armed_q <= 1'b1;
                done_q <= 1'b0;
                wr_cnt_q <= '0;
            end else if (armed_q && fv_rise) begin
                armed_q <= 1'b0;
                capturing_q <= 1'b1;
            end else if (capturing_q && fv_fall) begin
                capturing_q <= 1'b0;
                done_q <= 1'b1;
            end

            if (wr_en) begin
                wr_cnt_q <= wr_cnt_q + CNT_W'(1);
            end
        end
    end

    // RGB332 from the top bits of each channel
    always_comb begin
        wr_byte.fields.red = pix_if.red[PIX_W-1 -: 3];
        wr_byte.fields.green = pix_if.green[PIX_W-1 -: 3];
        wr_byte.fields.blue = pix_if.blue[PIX_W-1 -: 2];
    end

    always_ff @(posedge clock_spi_in) begin
        if (wr_en) begin
            mem[wr_cnt_q[BUF_AW-1:0]] <= wr_byte;
        end
        rd_data_o <= mem[rd_addr_i].raw;
    end

endmodule

// File: rtl/metering.sv
`timescale 1ns/1ps

module metering (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,
    pixel_if.sink pix_if,
    output logic [7:0] red_o,
    output logic [7:0] green_o,
    output logic [7:0] blue_o
);
    import cam_pix_pkg::*;

    // Wide enough for a full window of 8 bit samples
    logic [METER_SHIFT+7:0] red_sum_q;
    logic [METER_SHIFT+7:0] green_sum_q;
    logic [METER_SHIFT+7:0] blue_sum_q;
    logic frame_valid_q;
    logic pixel_valid;
    logic frame_end;

    assign pixel_valid = pix_if.frame_valid && pix_if.line_valid;
    assign frame_end = frame_valid_q && !pix_if.frame_valid;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            red_sum_q <= '0;
            green_sum_q <= '0;
            blue_sum_q <= '0;
            frame_valid_q <= 1'b0;
            red_o <= '0;
            green_o <= '0;
            blue_o <= '0;
        end else begin
            frame_valid_q <= pix_if.frame_valid;

            if (frame_end) begin
                // Divide by the pixel count and start over
                red_o <= red_sum_q[METER_SHIFT +: 8];
                green_o <= green_sum_q[METER_SHIFT +: 8];
                blue_o <= blue_sum_q[METER_SHIFT +: 8];
                red_sum_q <= '0;
                green_sum_q <= '0;
                blue_sum_q <= '0;
            end else if (pixel_valid) begin
                // Top 8 bits of each channel only
                red_sum_q <= red_sum_q + {{METER_SHIFT{1'b0}}, pix_if.red[PIX_W-1 -: 8]};
                green_sum_q <= green_sum_q + {{METER_SHIFT{1'b0}}, pix_if.green[PIX_W-1 -: 8]};
                blue_sum_q <= blue_sum_q + {{METER_SHIFT{1'b0}}, pix_if.blue[PIX_W-1 -: 8]};
            end
        end
    end

endmodule

// File: rtl/pixel_if.sv
`timescale 1ns/1ps

interface pixel_if;
    import cam_pix_pkg::*;

    logic frame_valid;
    logic line_valid;
    logic [PIX_W-1:0] red;
    logic [PIX_W-1:0] green;
    logic [PIX_W-1:0] blue;

    modport source (
        output frame_valid,
        output line_valid,
        output red,
        output green,
        output blue
    );

    modport sink (
        input frame_valid,
        input line_valid,
        input red,
        input green,
        input blue
    );

endinterface

// File: sim.f
rtl/cam_pix_pkg.sv
rtl/cam_reg_pkg.sv
rtl/pixel_if.sv
rtl/crop.sv
rtl/metering.sv
rtl/image_buffer.sv
rtl/cam_ctrl.sv
rtl/camera.sv
test/camera_chk.sv
test/camera_tb.sv

// File: test/camera_chk.sv
`timescale 1ns/1ps

module camera_chk (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,
    input logic psel_i,
    input logic penable_i,
    input logic pwrite_i,
    input logic [cam_reg_pkg::ADDR_W-1:0] paddr_i,
    input logic [cam_reg_pkg::DATA_W-1:0] prdata_i,
    input logic pready_i,
    input logic pslverr_i,
    input logic busy_i,
    input logic done_i
);
    import cam_reg_pkg::*;

    // APB ready only in an access phase and past the DATA read wait state
    ready_in_access: assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        pready_i |-> (psel_i && penable_i &&
                      (pwrite_i || paddr_i != REG_DATA || $past(penable_i))))
        else $error("pready is high outside an access phase or in a DATA wait state");

    // An error response also returns zero data
    ready_with_error: assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        pslverr_i |-> (pready_i && prdata_i == '0))
        else $error("pslverr is high without pready or with nonzero prdata");

    // Capture state is exclusive
    busy_excludes_done: assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        !(busy_i && done_i))
        else $error("busy and done are high together");

endmodule

bind camera camera_chk u_camera_chk (
    .clock_spi_in(clock_spi_in),
    .mipi_byte_reset_n(mipi_byte_reset_n),
    .psel_i(psel_i),
    .penable_i(penable_i),
    .pwrite_i(pwrite_i),
    .paddr_i(paddr_i),
    .prdata_i(prdata_o),
    .pready_i(pready_o),
    .pslverr_i(pslverr_o),
    .busy_i(busy),
    .done_i(done)
);

// File: test/camera_tb.sv
`timescale 1ns/1ps

module camera_tb;
    import cam_pix_pkg::*;
    import cam_reg_pkg::*;

    localparam int APB_TIMEOUT = 8;
    localparam int DONE_TIMEOUT = 50;
    localparam int LINE_GAP = 2;
    localparam int FRAME_GAP = 6;

    logic clock_spi_in = 1'b0;
    logic mipi_byte_reset_n;
    logic psel;
    logic penable;
    logic pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata_o;
    logic pready_o;
    logic pslverr_o;
    logic pix_frame_valid;
    logic pix_line_valid;
    logic [PIX_W-1:0] pix_red;
    logic [PIX_W-1:0] pix_green;
    logic [PIX_W-1:0] pix_blue;

    // Reference model of the last frame sent
    logic [7:0] exp_bytes [BUF_DEPTH];
    logic [DATA_W-1:0] exp_meter;
    logic [31:0] lcg_state = 32'h0d61_d08a;

    always #20 clock_spi_in = ~clock_spi_in;

    camera DUT (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .psel_i(psel),
        .penable_i(penable),
        .pwrite_i(pwrite),
        .paddr_i(paddr),
        .pwdata_i(pwdata),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .pix_frame_valid_i(pix_frame_valid),
        .pix_line_valid_i(pix_line_valid),
        .pix_red_i(pix_red),
        .pix_green_i(pix_green),
        .pix_blue_i(pix_blue)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Setup on one falling edge, access on the next, then poll pready
    task automatic apb_access(input logic write, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic err);
        int cycles;
        int exp_waits;
        cycles = 0;
        // Only DATA reads carry a wait state
        exp_waits = (!write && addr == REG_DATA) ? 1 : 0;
        @(negedge clock_spi_in);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clock_spi_in);
        penable = 1'b1;
        #1;
        while (!pready_o) begin
            cycles++;
            if (cycles > APB_TIMEOUT) begin
                stop_with_failure($sformatf("APB access to 0x%02h never completed", addr));
            end
            @(negedge clock_spi_in);
            #1;
        end
        assert (cycles == exp_waits)
            else stop_with_failure($sformatf(
                "ERROR at %0t: access to 0x%02h had %0d wait states, exp %0d",
                $time, addr, cycles, exp_waits));
        rdata = prdata_o;
        err = pslverr_o;
        @(negedge clock_spi_in);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] unused;
        logic err;
        apb_access(1'b1, addr, wdata, unused, err);
        assert (!err)
            else stop_with_failure($sformatf("ERROR at %0t: write to 0x%02h got pslverr",
                                             $time, addr));
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata,
                            output logic err);
        apb_access(1'b0, addr, '0, rdata, err);
    endtask

    task automatic check_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] got;
        logic err;
        apb_read(addr, got, err);
        assert (!err && got == exp)
            else stop_with_failure($sformatf(
                "ERROR at %0t: reg 0x%02h read 0x%08h err %0b, exp 0x%08h",
                $time, addr, got, err, exp));
    endtask

    // Drives one 16x12 frame of random pixels and models the crop window
    task automatic send_frame();
        logic [15:0] sum_r;
        logic [15:0] sum_g;
        logic [15:0] sum_b;
        int idx;
        sum_r = '0;
        sum_g = '0;
        sum_b = '0;
        idx = 0;
        @(negedge clock_spi_in);
        pix_frame_valid = 1'b1;
        repeat (2) @(negedge clock_spi_in);
        for (int row = 0; row < SENSOR_H; row++) begin
            for (int col = 0; col < SENSOR_W; col++) begin
                lcg_state = lcg_next(lcg_state);
                pix_red = lcg_state[31:22];
                lcg_state = lcg_next(lcg_state);
                pix_green = lcg_state[31:22];
                lcg_state = lcg_next(lcg_state);
                pix_blue = lcg_state[31:22];
                pix_line_valid = 1'b1;
                if (row >= CROP_Y0 && row < CROP_Y1 && col >= CROP_X0 && col < CROP_X1) begin
                    exp_bytes[idx] = {pix_red[9:7], pix_green[9:7], pix_blue[9:8]};
                    sum_r = sum_r + {8'h00, pix_red[9:2]};
                    sum_g = sum_g + {8'h00, pix_green[9:2]};
                    sum_b = sum_b + {8'h00, pix_blue[9:2]};
                    idx++;
                end
                @(negedge clock_spi_in);
            end
            pix_line_valid = 1'b0;
            repeat (LINE_GAP) @(negedge clock_spi_in);
        end
        pix_frame_valid = 1'b0;
        // Average over 64 pixels
        exp_meter = {8'h00, 8'(sum_b / BUF_DEPTH), 8'(sum_g / BUF_DEPTH),
                     8'(sum_r / BUF_DEPTH)};
        repeat (FRAME_GAP) @(negedge clock_spi_in);
    endtask

    task automatic wait_capture_done();
        logic [DATA_W-1:0] status;
        logic err;
        int polls;
        polls = 0;
        apb_read(REG_STATUS, status, err);
        while (!status[STAT_DONE]) begin
            polls++;
            if (polls > DONE_TIMEOUT) begin
                stop_with_failure("Capture never reported done in STATUS");
            end
            apb_read(REG_STATUS, status, err);
        end
    endtask

    task automatic read_capture();
        logic [DATA_W-1:0] got;
        logic err;
        for (int i = 0; i < BUF_DEPTH; i++) begin
            apb_read(REG_DATA, got, err);
            assert (!err && got == {24'h0, exp_bytes[i]})
                else stop_with_failure($sformatf("ERROR at %0t: byte %0d read 0x%02h, exp 0x%02h",
                                                 $time, i, got[7:0], exp_bytes[i]));
            check_reg(REG_AVAIL, 32'(BUF_DEPTH - i - 1));
        end
    endtask

    task automatic reset_values_read_zero();
        check_reg(REG_STATUS, 32'h0);
        check_reg(REG_AVAIL, 32'h0);
        check_reg(REG_METER, 32'h0);
    endtask

    task automatic capture_one_frame();
        apb_write(REG_CTRL, 32'h1);
        check_reg(REG_STATUS, 32'h1 << STAT_BUSY);
        send_frame();
        wait_capture_done();
        check_reg(REG_STATUS, 32'h1 << STAT_DONE);
        check_reg(REG_AVAIL, 32'(BUF_DEPTH));
        check_reg(REG_METER, exp_meter);
        read_capture();
    endtask

    // Request in mid frame, then a second request while capturing
    task automatic capture_waits_for_frame_start();
        fork
            send_frame();
            begin
                repeat (40) @(negedge clock_spi_in);
                apb_write(REG_CTRL, 32'h1);
            end
        join
        check_reg(REG_METER, exp_meter);
        check_reg(REG_STATUS, 32'h1 << STAT_BUSY);
        fork
            send_frame();
            begin
                repeat (60) @(negedge clock_spi_in);
                check_reg(REG_STATUS, 32'h1 << STAT_BUSY);
                apb_write(REG_CTRL, 32'h1);
            end
        join
        wait_capture_done();
        check_reg(REG_STATUS, 32'h1 << STAT_DONE);
        check_reg(REG_AVAIL, 32'(BUF_DEPTH));
        check_reg(REG_METER, exp_meter);
        read_capture();
    endtask

    task automatic unmapped_access_errors();
        logic [DATA_W-1:0] got;
        logic err;
        apb_read(8'h40, got, err);
        assert (err && got == 32'h0)
            else stop_with_failure($sformatf("ERROR at %0t: read of 0x40 gave 0x%08h err %0b",
                                             $time, got, err));
    endtask

    initial begin
        mipi_byte_reset_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pix_frame_valid = 1'b0;
        pix_line_valid = 1'b0;
        pix_red = '0;
        pix_green = '0;
        pix_blue = '0;
        exp_meter = '0;
        repeat (2) @(posedge clock_spi_in);
        @(negedge clock_spi_in);
        mipi_byte_reset_n = 1'b1;

        reset_values_read_zero();
        capture_one_frame();
        capture_waits_for_frame_start();
        unmapped_access_errors();

        $display("RESULT: PASS");
        $finish;
    end

endmodule
